/* verilog/gpio_pkg.sv */
package gpio_pkg;

    localparam int NUM_BANKS    = 4;
    localparam int GPIO_WIDTH   = 12;
    localparam int BANK_SEL_LSB = 12;    // 4 KB window per bank
    localparam int NUM_REGS     = 6;

    typedef logic [GPIO_WIDTH-1:0] gpio_vec_t;
    typedef logic [31:0]           apb_addr_t;
    typedef logic [31:0]           apb_data_t;
    typedef logic [9:0]            reg_idx_t;    // paddr[11:2]
    typedef logic [3:0]            bank_idx_t;   // paddr[15:12], wide enough to see bad banks
    typedef logic [NUM_BANKS-1:0]  bank_mask_t;

    // register word offsets within a bank
    localparam reg_idx_t REG_INPUT_VAL  = 10'd0;
    localparam reg_idx_t REG_INPUT_EN   = 10'd1;
    localparam reg_idx_t REG_OUTPUT_EN  = 10'd2;
    localparam reg_idx_t REG_OUTPUT_VAL = 10'd3;
    localparam reg_idx_t REG_IE         = 10'd4;
    localparam reg_idx_t REG_IP         = 10'd5;

    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_ACCESS,
        DEC_DONE
    } dec_state_t;

endpackage

/* verilog/apb_req_decoder.sv */
`timescale 1ns/1ps

module apb_req_decoder (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  gpio_pkg::apb_addr_t   i_paddr,
    input  gpio_pkg::apb_data_t   i_pwdata,
    output gpio_pkg::bank_mask_t  o_req_sel,
    output gpio_pkg::reg_idx_t    o_req_reg,
    output logic                  o_req_write,
    output gpio_pkg::apb_data_t   o_req_wdata,
    output logic                  o_dec_err_valid
);
    import gpio_pkg::*;

    dec_state_t r_state;
    logic       r_bad_bank;     // transfer aimed at a bank that does not exist
    logic       w_setup;
    bank_idx_t  w_bank;
    reg_idx_t   w_reg;

    assign w_setup = i_psel && !i_penable && (r_state == DEC_IDLE);
    assign w_bank  = i_paddr[BANK_SEL_LSB +: $bits(bank_idx_t)];
    assign w_reg   = i_paddr[BANK_SEL_LSB-1:2];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_state         <= DEC_IDLE;
            r_bad_bank      <= 1'b0;
            o_req_sel       <= '0;
            o_dec_err_valid <= 1'b0;
        end else begin
            o_req_sel       <= '0;      // strobe lasts one cycle
            o_dec_err_valid <= 1'b0;
            case (r_state)
                DEC_IDLE: begin
                    if (w_setup) begin
                        r_state    <= DEC_ACCESS;
                        r_bad_bank <= (w_bank >= NUM_BANKS);
                        if (w_bank < NUM_BANKS) begin
                            o_req_sel <= bank_mask_t'(1) << w_bank;
                        end
                    end
                end
                DEC_ACCESS: begin
                    // bank responses register here too, keep the error aligned
                    o_dec_err_valid <= r_bad_bank;
                    r_state         <= DEC_DONE;
                end
                DEC_DONE: begin
                    r_state <= DEC_IDLE;    // pready seen by the master this cycle
                end
                default: begin
                    r_state <= DEC_IDLE;
                end
            endcase
        end
    end

    // request payload, captured with the setup phase
    always_ff @(posedge i_clk) begin
        if (w_setup) begin
            o_req_reg   <= w_reg;
            o_req_write <= i_pwrite;
            o_req_wdata <= i_pwdata;
        end
    end

endmodule

/* verilog/gpio_bank.sv */
`timescale 1ns/1ps

module gpio_bank (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  logic                 i_req_valid,
    input  gpio_pkg::reg_idx_t   i_req_reg,
    input  logic                 i_req_write,
    input  gpio_pkg::apb_data_t  i_req_wdata,
    input  gpio_pkg::gpio_vec_t  i_gpio,
    output gpio_pkg::gpio_vec_t  o_gpio,
    output gpio_pkg::gpio_vec_t  o_gpio_dir,    // 1 = input
    output gpio_pkg::gpio_vec_t  o_gpio_oe,
    output gpio_pkg::gpio_vec_t  o_irq_lines,
    output logic                 o_resp_valid,
    output gpio_pkg::apb_data_t  o_resp_rdata,
    output logic                 o_resp_err
);
    import gpio_pkg::*;

    gpio_vec_t r_input_val;
    gpio_vec_t r_input_prev;    // input_val one cycle back, for edge detect
    gpio_vec_t r_input_en;
    gpio_vec_t r_output_en;
    gpio_vec_t r_output_val;
    gpio_vec_t r_ie;
    gpio_vec_t r_ip;

    logic      w_bad_reg;
    logic      w_wr;
    gpio_vec_t w_wdata;
    gpio_vec_t w_rise;
    gpio_vec_t w_ip_clr;
    apb_data_t w_rdata;

    assign w_bad_reg = (i_req_reg >= NUM_REGS);
    assign w_wr      = i_req_valid && i_req_write && !w_bad_reg;
    assign w_wdata   = i_req_wdata[GPIO_WIDTH-1:0];
    assign w_rise    = r_input_val & ~r_input_prev;
    assign w_ip_clr  = (w_wr && i_req_reg == REG_IP) ? w_wdata : '0;   // write 1 to clear

    always_comb begin
        case (i_req_reg)
            REG_INPUT_VAL:  w_rdata = apb_data_t'(r_input_val);
            REG_INPUT_EN:   w_rdata = apb_data_t'(r_input_en);
            REG_OUTPUT_EN:  w_rdata = apb_data_t'(r_output_en);
            REG_OUTPUT_VAL: w_rdata = apb_data_t'(r_output_val);
            REG_IE:         w_rdata = apb_data_t'(r_ie);
            REG_IP:         w_rdata = apb_data_t'(r_ip);
            default:        w_rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_input_val  <= '0;
            r_input_prev <= '0;
            r_input_en   <= '1;         // all pins start as inputs
            r_output_en  <= '0;
            r_output_val <= '0;
            r_ie         <= '0;
            r_ip         <= '0;
            o_resp_valid <= 1'b0;
            o_resp_err   <= 1'b0;
        end else begin
            r_input_val  <= i_gpio & r_input_en;
            r_input_prev <= r_input_val;
            r_ip         <= (r_ip & ~w_ip_clr) | w_rise;   // new edge beats the clear
            if (w_wr) begin
                case (i_req_reg)
                    REG_INPUT_EN:   r_input_en   <= w_wdata;
                    REG_OUTPUT_EN:  r_output_en  <= w_wdata;
                    REG_OUTPUT_VAL: r_output_val <= w_wdata;
                    REG_IE:         r_ie         <= w_wdata;
                    default: begin
                        // input_val is read only, ip handled above
                    end
                endcase
            end
            o_resp_valid <= i_req_valid;
            o_resp_err   <= i_req_valid && w_bad_reg;
        end
    end

    // read data only matters while resp_valid is high
    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            o_resp_rdata <= w_rdata;
        end
    end

    assign o_gpio      = r_output_val;
    assign o_gpio_dir  = r_input_en;
    assign o_gpio_oe   = r_output_en;
    assign o_irq_lines = r_ie & r_ip;

endmodule

/* verilog/gpio_resp_merge.sv */
`timescale 1ns/1ps

module gpio_resp_merge (
    input  gpio_pkg::bank_mask_t                          i_resp_valid,
    input  gpio_pkg::apb_data_t [gpio_pkg::NUM_BANKS-1:0] i_resp_rdata,
    input  gpio_pkg::bank_mask_t                          i_resp_err,
    input  logic                                          i_dec_err_valid,
    input  gpio_pkg::gpio_vec_t [gpio_pkg::NUM_BANKS-1:0] i_irq_lines,
    output logic                                          o_pready,
    output gpio_pkg::apb_data_t                           o_prdata,
    output logic                                          o_pslverr,
    output gpio_pkg::bank_mask_t                          o_irq
);
    import gpio_pkg::*;

    // decoder error counts as a response of its own
    assign o_pready  = (|i_resp_valid) | i_dec_err_valid;
    assign o_pslverr = (|(i_resp_valid & i_resp_err)) | i_dec_err_valid;

    // at most one bank answers, so OR of gated data is a mux
    always_comb begin
        o_prdata = '0;
        for (int k = 0; k < NUM_BANKS; k++) begin
            if (i_resp_valid[k]) begin
                o_prdata = o_prdata | i_resp_rdata[k];
            end
        end
    end

    // one interrupt per bank
    always_comb begin
        for (int k = 0; k < NUM_BANKS; k++) begin
            o_irq[k] = |i_irq_lines[k];
        end
    end

endmodule

/* verilog/gpio_subsys_top.sv */
`timescale 1ns/1ps

module gpio_subsys_top (
    input  logic                                          i_clk,
    input  logic                                          i_nrst,
    input  logic                                          i_psel,
    input  logic                                          i_penable,
    input  logic                                          i_pwrite,
    input  gpio_pkg::apb_addr_t                           i_paddr,
    input  gpio_pkg::apb_data_t                           i_pwdata,
    output logic                                          o_pready,
    output gpio_pkg::apb_data_t                           o_prdata,
    output logic                                          o_pslverr,
    input  gpio_pkg::gpio_vec_t [gpio_pkg::NUM_BANKS-1:0] i_gpio,
    output gpio_pkg::gpio_vec_t [gpio_pkg::NUM_BANKS-1:0] o_gpio,
    output gpio_pkg::gpio_vec_t [gpio_pkg::NUM_BANKS-1:0] o_gpio_dir,
    output gpio_pkg::gpio_vec_t [gpio_pkg::NUM_BANKS-1:0] o_gpio_oe,
    output gpio_pkg::bank_mask_t                          o_irq
);
    import gpio_pkg::*;

    bank_mask_t                  w_req_sel;
    reg_idx_t                    w_req_reg;
    logic                        w_req_write;
    apb_data_t                   w_req_wdata;
    logic                        w_dec_err_valid;
    bank_mask_t                  w_resp_valid;
    bank_mask_t                  w_resp_err;
    apb_data_t [NUM_BANKS-1:0]   w_resp_rdata;
    gpio_vec_t [NUM_BANKS-1:0]   w_irq_lines;

    apb_req_decoder u_dec (
        .i_clk           (i_clk),
        .i_nrst          (i_nrst),
        .i_psel          (i_psel),
        .i_penable       (i_penable),
        .i_pwrite        (i_pwrite),
        .i_paddr         (i_paddr),
        .i_pwdata        (i_pwdata),
        .o_req_sel       (w_req_sel),
        .o_req_reg       (w_req_reg),
        .o_req_write     (w_req_write),
        .o_req_wdata     (w_req_wdata),
        .o_dec_err_valid (w_dec_err_valid)
    );

    for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
        gpio_bank u_bank (
            .i_clk        (i_clk),
            .i_nrst       (i_nrst),
            .i_req_valid  (w_req_sel[k]),   // own select bit only
            .i_req_reg    (w_req_reg),
            .i_req_write  (w_req_write),
            .i_req_wdata  (w_req_wdata),
            .i_gpio       (i_gpio[k]),
            .o_gpio       (o_gpio[k]),
            .o_gpio_dir   (o_gpio_dir[k]),
            .o_gpio_oe    (o_gpio_oe[k]),
            .o_irq_lines  (w_irq_lines[k]),
            .o_resp_valid (w_resp_valid[k]),
            .o_resp_rdata (w_resp_rdata[k]),
            .o_resp_err   (w_resp_err[k])
        );
    end

    gpio_resp_merge u_merge (
        .i_resp_valid    (w_resp_valid),
        .i_resp_rdata    (w_resp_rdata),
        .i_resp_err      (w_resp_err),
        .i_dec_err_valid (w_dec_err_valid),
        .i_irq_lines     (w_irq_lines),
        .o_pready        (o_pready),
        .o_prdata        (o_prdata),
        .o_pslverr       (o_pslverr),
        .o_irq           (o_irq)
    );

endmodule

/* tests/tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;    // 4 ns period
    end

    // reset held for 10 cycles, released away from the rising edge
    initial begin
        o_nrst = 1'b0;
        repeat (10) @(posedge o_clk);
        @(negedge o_clk);
        o_nrst = 1'b1;
    end

endmodule

/* tests/tb_gpio_subsys.sv */
`timescale 1ns/1ps

module tb_gpio_subsys;
    import gpio_pkg::*;

    typedef enum logic [1:0] {OP_WR, OP_RD, OP_PINS} op_t;

    typedef struct packed {
        op_t                        op;
        bank_idx_t                  bank;
        reg_idx_t                   regi;
        apb_data_t                  data;
        apb_data_t                  exp_rdata;
        logic                       exp_err;
        gpio_vec_t [NUM_BANKS-1:0]  exp_out;
        gpio_vec_t [NUM_BANKS-1:0]  exp_dir;
        gpio_vec_t [NUM_BANKS-1:0]  exp_oe;
        bank_mask_t                 exp_irq;
    } row_t;

    logic                       clk;
    logic                       nrst;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    apb_addr_t                  paddr;
    apb_data_t                  pwdata;
    logic                       pready;
    apb_data_t                  prdata;
    logic                       pslverr;
    gpio_vec_t [NUM_BANKS-1:0]  gpio_in;
    gpio_vec_t [NUM_BANKS-1:0]  gpio_out;
    gpio_vec_t [NUM_BANKS-1:0]  gpio_dir;
    gpio_vec_t [NUM_BANKS-1:0]  gpio_oe;
    bank_mask_t                 irq;

    // reference model of every bank
    gpio_vec_t m_pins [NUM_BANKS];
    gpio_vec_t m_in_val [NUM_BANKS];
    gpio_vec_t m_in_en [NUM_BANKS];
    gpio_vec_t m_out_en [NUM_BANKS];
    gpio_vec_t m_out_val [NUM_BANKS];
    gpio_vec_t m_ie [NUM_BANKS];
    gpio_vec_t m_ip [NUM_BANKS];

    row_t        rows [128];
    int          n_rows;
    logic [31:0] lcg_state;

    tb_clkgen u_clkgen (
        .o_clk  (clk),
        .o_nrst (nrst)
    );

    gpio_subsys_top gpio_subsys_top_i (
        .i_clk      (clk),
        .i_nrst     (nrst),
        .i_psel     (psel),
        .i_penable  (penable),
        .i_pwrite   (pwrite),
        .i_paddr    (paddr),
        .i_pwdata   (pwdata),
        .o_pready   (pready),
        .o_prdata   (prdata),
        .o_pslverr  (pslverr),
        .i_gpio     (gpio_in),
        .o_gpio     (gpio_out),
        .o_gpio_dir (gpio_dir),
        .o_gpio_oe  (gpio_oe),
        .o_irq      (irq)
    );

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(string name, apb_data_t got, apb_data_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_pins(string name, int bank, gpio_vec_t got, gpio_vec_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s[%0d] got 0x%h expected 0x%h",
                                    name, bank, got, exp));
        end
    endtask

    task automatic check_irq(bank_mask_t got, bank_mask_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] o_irq got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_err(string name, logic got, logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("[FAIL] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic apb_data_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic apb_addr_t make_addr(bank_idx_t bank, reg_idx_t regi);
        return {16'h0000, bank, regi, 2'b00};
    endfunction

    function automatic apb_data_t model_read(int b, reg_idx_t regi);
        gpio_vec_t v;
        case (regi)
            REG_INPUT_VAL:  v = m_in_val[b];
            REG_INPUT_EN:   v = m_in_en[b];
            REG_OUTPUT_EN:  v = m_out_en[b];
            REG_OUTPUT_VAL: v = m_out_val[b];
            REG_IE:         v = m_ie[b];
            default:        v = m_ip[b];
        endcase
        return {{(32-GPIO_WIDTH){1'b0}}, v};    // zero-extended
    endfunction

    task automatic model_write(int b, reg_idx_t regi, gpio_vec_t v);
        case (regi)
            REG_INPUT_EN:   m_in_en[b] = v;
            REG_OUTPUT_EN:  m_out_en[b] = v;
            REG_OUTPUT_VAL: m_out_val[b] = v;
            REG_IE:         m_ie[b] = v;
            REG_IP:         m_ip[b] = m_ip[b] & ~v;    // write 1 clears
            default: begin
            end
        endcase
    endtask

    // masked inputs settle and rising bits set pending
    task automatic model_settle();
        gpio_vec_t nv;
        for (int b = 0; b < NUM_BANKS; b++) begin
            nv = m_pins[b] & m_in_en[b];
            m_ip[b] = m_ip[b] | (nv & ~m_in_val[b]);
            m_in_val[b] = nv;
        end
    endtask

    task automatic add_row(op_t op, bank_idx_t bank, reg_idx_t regi, apb_data_t data);
        row_t r;
        logic bad;
        int   b;
        b = int'(bank);
        bad = (b >= NUM_BANKS) || (int'(regi) >= NUM_REGS);
        r = '0;
        r.op = op;
        r.bank = bank;
        r.regi = regi;
        r.data = data;
        if (op == OP_PINS) begin
            m_pins[b] = data[GPIO_WIDTH-1:0];
        end else begin
            r.exp_err = bad;
            if (op == OP_RD && !bad) r.exp_rdata = model_read(b, regi);
            if (op == OP_WR && !bad) model_write(b, regi, data[GPIO_WIDTH-1:0]);
        end
        model_settle();
        for (int k = 0; k < NUM_BANKS; k++) begin
            r.exp_out[k] = m_out_val[k];
            r.exp_dir[k] = m_in_en[k];
            r.exp_oe[k]  = m_out_en[k];
            r.exp_irq[k] = |(m_ie[k] & m_ip[k]);
        end
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic build_table();
        for (int b = 0; b < NUM_BANKS; b++) begin
            m_pins[b] = '0;
            m_in_val[b] = '0;
            m_in_en[b] = '1;
            m_out_en[b] = '0;
            m_out_val[b] = '0;
            m_ie[b] = '0;
            m_ip[b] = '0;
        end
        n_rows = 0;
        for (int b = 0; b < NUM_BANKS; b++) begin    // reset values
            for (int r = 0; r < NUM_REGS; r++) add_row(OP_RD, bank_idx_t'(b), reg_idx_t'(r), '0);
        end
        for (int b = 0; b < NUM_BANKS; b++) begin    // random writes with read back
            for (int r = 1; r <= 4; r++) begin
                add_row(OP_WR, bank_idx_t'(b), reg_idx_t'(r), lcg_next());
                add_row(OP_RD, bank_idx_t'(b), reg_idx_t'(r), '0);
            end
        end
        for (int b = 0; b < NUM_BANKS; b += 2) begin
            add_row(OP_WR, bank_idx_t'(b), REG_INPUT_EN, lcg_next() | 32'h1);
            add_row(OP_PINS, bank_idx_t'(b), '0, lcg_next() | 32'h1);   // pin 0 always rises
            add_row(OP_RD, bank_idx_t'(b), REG_INPUT_VAL, '0);
            add_row(OP_RD, bank_idx_t'(b), REG_IP, '0);
            add_row(OP_WR, bank_idx_t'(b), REG_IE, 32'hFFF);
            add_row(OP_WR, bank_idx_t'(b), REG_IP, 32'h00F);    // partial clear
            add_row(OP_RD, bank_idx_t'(b), REG_IP, '0);
            add_row(OP_WR, bank_idx_t'(b), REG_IP, 32'hFFF);
            add_row(OP_RD, bank_idx_t'(b), REG_IP, '0);
            add_row(OP_PINS, bank_idx_t'(b), '0, '0);
        end
        add_row(OP_WR, 4'd1, REG_INPUT_VAL, 32'hFFF);   // ignored write to a read-only register
        add_row(OP_RD, 4'd1, REG_INPUT_VAL, '0);
        add_row(OP_WR, 4'd4, REG_OUTPUT_VAL, lcg_next());
        add_row(OP_RD, 4'd4, REG_INPUT_EN, '0);
        add_row(OP_RD, 4'd15, REG_INPUT_VAL, '0);
        add_row(OP_WR, 4'd3, 10'h043, lcg_next());     // low bits alias output_val
        add_row(OP_RD, 4'd3, 10'd6, '0);
        add_row(OP_RD, 4'd3, 10'h3FC, '0);             // low bits alias ie
        for (int b = 0; b < NUM_BANKS; b++) begin    // nothing moved
            for (int r = 1; r < NUM_REGS; r++) add_row(OP_RD, bank_idx_t'(b), reg_idx_t'(r), '0);
        end
    endtask

    // both access cycles after the setup phase
    task automatic run_access(output apb_data_t rdata, output logic err);
        int waits;
        @(negedge clk);
        if (pready !== 1'b0) stop_on_error("o_pready was high in the first access cycle");
        penable = 1'b1;
        waits = 0;
        do begin
            @(negedge clk);
            waits++;
            if (waits > 20) stop_on_error("timeout while waiting for o_pready");
        end while (pready !== 1'b1);
        if (waits != 1) stop_on_error("o_pready did not come in the second access cycle");
        rdata = prdata;
        err = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apb_write(apb_addr_t addr, apb_data_t data, output logic err);
        apb_data_t unused_rdata;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        run_access(unused_rdata, err);
    endtask

    task automatic apb_read(apb_addr_t addr, output apb_data_t rdata, output logic err);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = addr;
        pwdata = '0;
        run_access(rdata, err);
    endtask

    task automatic check_outputs(row_t r, int i);
        for (int k = 0; k < NUM_BANKS; k++) begin
            check_pins($sformatf("o_gpio (row %0d)", i), k, gpio_out[k], r.exp_out[k]);
            check_pins($sformatf("o_gpio_dir (row %0d)", i), k, gpio_dir[k], r.exp_dir[k]);
            check_pins($sformatf("o_gpio_oe (row %0d)", i), k, gpio_oe[k], r.exp_oe[k]);
        end
        check_irq(irq, r.exp_irq);
    endtask

    initial begin
        int        waits;
        apb_data_t rdata;
        logic      err;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        gpio_in = '0;
        lcg_state = 32'd1825;
        build_table();

        waits = 0;
        while (nrst !== 1'b1) begin
            @(negedge clk);
            waits++;
            if (waits > 50) stop_on_error("reset was never released");
        end
        check_outputs(rows[0], 0);    // first row is a read and leaves the reset outputs

        for (int i = 0; i < n_rows; i++) begin
            case (rows[i].op)
                OP_PINS: begin
                    @(negedge clk);
                    gpio_in[int'(rows[i].bank)] = rows[i].data[GPIO_WIDTH-1:0];
                end
                OP_WR: begin
                    apb_write(make_addr(rows[i].bank, rows[i].regi), rows[i].data, err);
                    check_err($sformatf("o_pslverr (row %0d)", i), err, rows[i].exp_err);
                end
                default: begin
                    apb_read(make_addr(rows[i].bank, rows[i].regi), rdata, err);
                    check_err($sformatf("o_pslverr (row %0d)", i), err, rows[i].exp_err);
                    check_data($sformatf("o_prdata (row %0d)", i), rdata, rows[i].exp_rdata);
                end
            endcase
            repeat (3) @(negedge clk);    // input_val then ip settle
            check_outputs(rows[i], i);
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* build.f */
verilog/gpio_pkg.sv
verilog/apb_req_decoder.sv
verilog/gpio_bank.sv
verilog/gpio_resp_merge.sv
verilog/gpio_subsys_top.sv
tests/tb_clkgen.sv
tests/tb_gpio_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing -j 0 \
    --top-module tb_gpio_subsys \
    --Mdir obj_dir -o tb_gpio_subsys \
    -f build.f

./obj_dir/tb_gpio_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
    exit 0
fi
exit 1
